//--- source/mem_unit_defs.svh
`ifndef MEM_UNIT_DEFS_SVH
`define MEM_UNIT_DEFS_SVH

// Memory line geometry
`define MEM_ADDR_WIDTH      26
`define MEM_DATA_WIDTH      64
`define MEM_BYTEEN_WIDTH    8

// Client tags
`define ICACHE_TAG_WIDTH    4
`define DCACHE_TAG_WIDTH    5

// Widest client tag plus the source bit on top
`define MEM_TAG_WIDTH       6

// Performance counter width
`define PERF_CTR_BITS       44

// Entries in each skid buffer
`define SKID_DEPTH          2

`endif

//--- source/mem_unit_pkg.sv
`default_nettype none

`include "mem_unit_defs.svh"

package mem_unit_pkg;

    // Instruction fetch request, read only
    typedef struct packed {
        logic [`MEM_ADDR_WIDTH-1:0]   addr;
        logic [`ICACHE_TAG_WIDTH-1:0] tag;
    } icache_req_t;

    typedef struct packed {
        logic                         rw;
        logic [`MEM_BYTEEN_WIDTH-1:0] byteen;
        logic [`MEM_ADDR_WIDTH-1:0]   addr;
        logic [`MEM_DATA_WIDTH-1:0]   data;
        logic [`DCACHE_TAG_WIDTH-1:0] tag;
    } dcache_req_t;

    // Tag carries the source bit in its top position
    typedef struct packed {
        logic                         rw;
        logic [`MEM_BYTEEN_WIDTH-1:0] byteen;
        logic [`MEM_ADDR_WIDTH-1:0]   addr;
        logic [`MEM_DATA_WIDTH-1:0]   data;
        logic [`MEM_TAG_WIDTH-1:0]    tag;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0]   data;
        logic [`MEM_TAG_WIDTH-1:0]    tag;
    } mem_rsp_t;

    typedef logic [`PERF_CTR_BITS-1:0] perf_ctr_t;

endpackage

`default_nettype wire

//--- source/mem_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module mem_skid_buffer
    import mem_unit_pkg::*;
#(
    parameter type payload_t = mem_rsp_t
) (
    input  wire           clk,
    input  wire           reset,

    input  wire           valid_in,
    input  wire payload_t data_in,
    output logic          ready_in,

    output logic          valid_out,
    output payload_t      data_out,
    input  wire           ready_out
);

    // Second entry catches a transfer that lands while the output stalls
    logic     skid_valid;
    payload_t skid_data;

    // Registered ready, low only with both entries full
    assign ready_in = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            // Output stays valid while the skid entry drains into it
            if (ready_out) begin
                skid_valid <= 1'b0;
            end
        end else if (!valid_out || ready_out) begin
            valid_out <= valid_in;
        end else if (valid_in) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_valid) begin
            if (ready_out) begin
                data_out <= skid_data;
            end
        end else if (!valid_out || ready_out) begin
            if (valid_in) begin
                data_out <= data_in;
            end
        end else if (valid_in) begin
            skid_data <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_req_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_defs.svh"

module mem_req_arb
    import mem_unit_pkg::*;
(
    input  wire              clk,
    input  wire              reset,

    input  wire              icache_valid,
    input  wire icache_req_t icache_req,
    output logic             icache_ready,

    input  wire              dcache_valid,
    input  wire dcache_req_t dcache_req,
    output logic             dcache_ready,

    output logic             mem_req_valid,
    output mem_req_t         mem_req,
    input  wire              mem_req_ready
);

    localparam int CLIENT_TAG_WIDTH = `MEM_TAG_WIDTH - 1;

    logic prio_dcache;
    logic locked;
    logic locked_dcache;
    logic pick_dcache;
    logic grant_dcache;

    // Round robin pick, but a stalled request keeps its grant
    assign pick_dcache  = dcache_valid && (prio_dcache || !icache_valid);
    assign grant_dcache = locked ? locked_dcache : pick_dcache;

    assign mem_req_valid = icache_valid || dcache_valid;
    assign icache_ready  = mem_req_ready && !grant_dcache;
    assign dcache_ready  = mem_req_ready && grant_dcache;

    always_comb begin
        if (grant_dcache) begin
            mem_req.rw     = dcache_req.rw;
            mem_req.byteen = dcache_req.byteen;
            mem_req.addr   = dcache_req.addr;
            mem_req.data   = dcache_req.data;
            mem_req.tag    = {1'b1, CLIENT_TAG_WIDTH'(dcache_req.tag)};
        end else begin
            // Fetches are plain line reads
            mem_req.rw     = 1'b0;
            mem_req.byteen = '0;
            mem_req.addr   = icache_req.addr;
            mem_req.data   = '0;
            mem_req.tag    = {1'b0, CLIENT_TAG_WIDTH'(icache_req.tag)};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_dcache   <= 1'b0;
            locked        <= 1'b0;
            locked_dcache <= 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                prio_dcache <= !grant_dcache;
            end
            locked        <= mem_req_valid && !mem_req_ready;
            locked_dcache <= grant_dcache;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_rsp_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_defs.svh"

module mem_rsp_router
    import mem_unit_pkg::*;
(
    input  wire                          clk,
    input  wire                          reset,

    input  wire                          mem_rsp_valid,
    input  wire mem_rsp_t                mem_rsp,
    output logic                         mem_rsp_ready,

    output logic                         icache_rsp_valid,
    output logic [`MEM_DATA_WIDTH-1:0]   icache_rsp_data,
    output logic [`ICACHE_TAG_WIDTH-1:0] icache_rsp_tag,
    input  wire                          icache_rsp_ready,

    output logic                         dcache_rsp_valid,
    output logic [`MEM_DATA_WIDTH-1:0]   dcache_rsp_data,
    output logic [`DCACHE_TAG_WIDTH-1:0] dcache_rsp_tag,
    input  wire                          dcache_rsp_ready
);

    logic     rsp_buf_valid;
    mem_rsp_t rsp_buf;
    logic     rsp_buf_ready;
    logic     rsp_to_dcache;

    mem_skid_buffer #(
        .payload_t (mem_rsp_t)
    ) rsp_buf_inst (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mem_rsp_valid),
        .data_in   (mem_rsp),
        .ready_in  (mem_rsp_ready),
        .valid_out (rsp_buf_valid),
        .data_out  (rsp_buf),
        .ready_out (rsp_buf_ready)
    );

    assign rsp_to_dcache = rsp_buf.tag[`MEM_TAG_WIDTH-1];

    // Head of buffer waits on its own client only
    assign rsp_buf_ready = rsp_to_dcache ? dcache_rsp_ready : icache_rsp_ready;

    assign icache_rsp_valid = rsp_buf_valid && !rsp_to_dcache;
    assign icache_rsp_data  = rsp_buf.data;
    assign icache_rsp_tag   = rsp_buf.tag[`ICACHE_TAG_WIDTH-1:0];

    assign dcache_rsp_valid = rsp_buf_valid && rsp_to_dcache;
    assign dcache_rsp_data  = rsp_buf.data;
    assign dcache_rsp_tag   = rsp_buf.tag[`DCACHE_TAG_WIDTH-1:0];

endmodule

`default_nettype wire

//--- source/mem_perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module mem_perf_counters
    import mem_unit_pkg::*;
(
    input  wire       clk,
    input  wire       reset,

    input  wire       mem_req_valid,
    input  wire       mem_req_rw,
    input  wire       mem_req_ready,
    input  wire       mem_rsp_valid,
    input  wire       mem_rsp_ready,

    output perf_ctr_t perf_mem_reads,
    output perf_ctr_t perf_mem_writes,
    output perf_ctr_t perf_mem_stalls,
    output perf_ctr_t perf_mem_latency
);

    logic      read_fire;
    logic      write_fire;
    logic      rsp_fire;
    perf_ctr_t reads_pending;

    assign read_fire  = mem_req_valid && mem_req_ready && !mem_req_rw;
    assign write_fire = mem_req_valid && mem_req_ready && mem_req_rw;
    assign rsp_fire   = mem_rsp_valid && mem_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            reads_pending    <= '0;
            perf_mem_reads   <= '0;
            perf_mem_writes  <= '0;
            perf_mem_stalls  <= '0;
            perf_mem_latency <= '0;
        end else begin
            if (read_fire && !rsp_fire) begin
                reads_pending <= reads_pending + 1'b1;
            end else if (rsp_fire && !read_fire) begin
                reads_pending <= reads_pending - 1'b1;
            end
            if (read_fire) begin
                perf_mem_reads <= perf_mem_reads + 1'b1;
            end
            if (write_fire) begin
                perf_mem_writes <= perf_mem_writes + 1'b1;
            end
            if (mem_req_valid && !mem_req_ready) begin
                perf_mem_stalls <= perf_mem_stalls + 1'b1;
            end
            // Reads in flight during this cycle
            perf_mem_latency <= perf_mem_latency + reads_pending;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_defs.svh"

module mem_unit
    import mem_unit_pkg::*;
(
    input  wire                          clk,
    input  wire                          reset,

    input  wire                          icache_req_valid,
    input  wire  [`MEM_ADDR_WIDTH-1:0]   icache_req_addr,
    input  wire  [`ICACHE_TAG_WIDTH-1:0] icache_req_tag,
    output logic                         icache_req_ready,

    output logic                         icache_rsp_valid,
    output logic [`MEM_DATA_WIDTH-1:0]   icache_rsp_data,
    output logic [`ICACHE_TAG_WIDTH-1:0] icache_rsp_tag,
    input  wire                          icache_rsp_ready,

    input  wire                          dcache_req_valid,
    input  wire                          dcache_req_rw,
    input  wire  [`MEM_BYTEEN_WIDTH-1:0] dcache_req_byteen,
    input  wire  [`MEM_ADDR_WIDTH-1:0]   dcache_req_addr,
    input  wire  [`MEM_DATA_WIDTH-1:0]   dcache_req_data,
    input  wire  [`DCACHE_TAG_WIDTH-1:0] dcache_req_tag,
    output logic                         dcache_req_ready,

    output logic                         dcache_rsp_valid,
    output logic [`MEM_DATA_WIDTH-1:0]   dcache_rsp_data,
    output logic [`DCACHE_TAG_WIDTH-1:0] dcache_rsp_tag,
    input  wire                          dcache_rsp_ready,

    output logic                         mem_req_valid,
    output logic                         mem_req_rw,
    output logic [`MEM_BYTEEN_WIDTH-1:0] mem_req_byteen,
    output logic [`MEM_ADDR_WIDTH-1:0]   mem_req_addr,
    output logic [`MEM_DATA_WIDTH-1:0]   mem_req_data,
    output logic [`MEM_TAG_WIDTH-1:0]    mem_req_tag,
    input  wire                          mem_req_ready,

    input  wire                          mem_rsp_valid,
    input  wire  [`MEM_DATA_WIDTH-1:0]   mem_rsp_data,
    input  wire  [`MEM_TAG_WIDTH-1:0]    mem_rsp_tag,
    output logic                         mem_rsp_ready,

    output perf_ctr_t                    perf_mem_reads,
    output perf_ctr_t                    perf_mem_writes,
    output perf_ctr_t                    perf_mem_stalls,
    output perf_ctr_t                    perf_mem_latency
);

    icache_req_t icache_req_in;
    dcache_req_t dcache_req_in;
    mem_rsp_t    mem_rsp_in;
    mem_req_t    mem_req;

    logic        icache_buf_valid;
    icache_req_t icache_buf_req;
    logic        icache_buf_ready;
    logic        dcache_buf_valid;
    dcache_req_t dcache_buf_req;
    logic        dcache_buf_ready;

    assign icache_req_in = '{addr: icache_req_addr, tag: icache_req_tag};
    assign dcache_req_in = '{rw: dcache_req_rw, byteen: dcache_req_byteen,
                             addr: dcache_req_addr, data: dcache_req_data,
                             tag: dcache_req_tag};
    assign mem_rsp_in    = '{data: mem_rsp_data, tag: mem_rsp_tag};

    assign mem_req_rw     = mem_req.rw;
    assign mem_req_byteen = mem_req.byteen;
    assign mem_req_addr   = mem_req.addr;
    assign mem_req_data   = mem_req.data;
    assign mem_req_tag    = mem_req.tag;

    // Client request buffers
    mem_skid_buffer #(
        .payload_t (icache_req_t)
    ) icache_req_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (icache_req_valid),
        .data_in   (icache_req_in),
        .ready_in  (icache_req_ready),
        .valid_out (icache_buf_valid),
        .data_out  (icache_buf_req),
        .ready_out (icache_buf_ready)
    );

    mem_skid_buffer #(
        .payload_t (dcache_req_t)
    ) dcache_req_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (dcache_req_valid),
        .data_in   (dcache_req_in),
        .ready_in  (dcache_req_ready),
        .valid_out (dcache_buf_valid),
        .data_out  (dcache_buf_req),
        .ready_out (dcache_buf_ready)
    );

    mem_req_arb req_arb (
        .clk           (clk),
        .reset         (reset),
        .icache_valid  (icache_buf_valid),
        .icache_req    (icache_buf_req),
        .icache_ready  (icache_buf_ready),
        .dcache_valid  (dcache_buf_valid),
        .dcache_req    (dcache_buf_req),
        .dcache_ready  (dcache_buf_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready)
    );

    mem_rsp_router rsp_router (
        .clk              (clk),
        .reset            (reset),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp          (mem_rsp_in),
        .mem_rsp_ready    (mem_rsp_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_data  (icache_rsp_data),
        .icache_rsp_tag   (icache_rsp_tag),
        .icache_rsp_ready (icache_rsp_ready),
        .dcache_rsp_valid (dcache_rsp_valid),
        .dcache_rsp_data  (dcache_rsp_data),
        .dcache_rsp_tag   (dcache_rsp_tag),
        .dcache_rsp_ready (dcache_rsp_ready)
    );

    // Counters watch the external memory port
    mem_perf_counters perf_counters (
        .clk              (clk),
        .reset            (reset),
        .mem_req_valid    (mem_req_valid),
        .mem_req_rw       (mem_req_rw),
        .mem_req_ready    (mem_req_ready),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp_ready    (mem_rsp_ready),
        .perf_mem_reads   (perf_mem_reads),
        .perf_mem_writes  (perf_mem_writes),
        .perf_mem_stalls  (perf_mem_stalls),
        .perf_mem_latency (perf_mem_latency)
    );

endmodule

`default_nettype wire

//--- dv/mem_unit_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_defs.svh"

module mem_unit_mem_model #(
    parameter int MAX_DELAY = 8
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          always_ready,

    input  wire                          req_valid,
    input  wire                          req_rw,
    input  wire  [`MEM_BYTEEN_WIDTH-1:0] req_byteen,
    input  wire  [`MEM_ADDR_WIDTH-1:0]   req_addr,
    input  wire  [`MEM_DATA_WIDTH-1:0]   req_data,
    input  wire  [`MEM_TAG_WIDTH-1:0]    req_tag,
    output logic                         req_ready,

    output logic                         rsp_valid,
    output logic [`MEM_DATA_WIDTH-1:0]   rsp_data,
    output logic [`MEM_TAG_WIDTH-1:0]    rsp_tag,
    input  wire                          rsp_ready
);

    logic [`MEM_DATA_WIDTH-1:0] mem [logic [`MEM_ADDR_WIDTH-1:0]];
    logic [`MEM_DATA_WIDTH-1:0] q_data [$];
    logic [`MEM_TAG_WIDTH-1:0]  q_tag [$];
    int                         q_due [$];
    int                         cycle;
    int                         rsp_issued;
    int                         rsp_accepts;

    // Unwritten lines read back the address in both halves
    function automatic logic [`MEM_DATA_WIDTH-1:0] fill_line(
        input logic [`MEM_ADDR_WIDTH-1:0] addr);
        return {6'h15, addr, 6'h2a, ~addr};
    endfunction

    function automatic logic [`MEM_DATA_WIDTH-1:0] read_line(
        input logic [`MEM_ADDR_WIDTH-1:0] addr);
        return mem.exists(addr) ? mem[addr] : fill_line(addr);
    endfunction

    initial begin
        req_ready   = 1'b0;
        rsp_valid   = 1'b0;
        rsp_data    = '0;
        rsp_tag     = '0;
        cycle       = 0;
        rsp_issued  = 0;
        rsp_accepts = 0;
    end

    always @(posedge clk) begin
        logic [`MEM_DATA_WIDTH-1:0] line;
        cycle++;
        if (!reset) begin
            if (rsp_valid && rsp_ready) begin
                void'(q_data.pop_front());
                void'(q_tag.pop_front());
                void'(q_due.pop_front());
                rsp_accepts++;
            end
            if (req_valid && req_ready) begin
                line = read_line(req_addr);
                if (req_rw) begin
                    for (int i = 0; i < `MEM_BYTEEN_WIDTH; i++) begin
                        if (req_byteen[i]) begin
                            line[8*i +: 8] = req_data[8*i +: 8];
                        end
                    end
                    mem[req_addr] = line;
                end else begin
                    q_data.push_back(line);
                    q_tag.push_back(req_tag);
                    q_due.push_back(cycle + 1 + int'($urandom % MAX_DELAY));
                end
            end
        end
    end

    always @(negedge clk) begin
        req_ready = always_ready ? 1'b1 : 1'($urandom);
        // Next response only once the current one is taken
        if (rsp_issued == rsp_accepts) begin
            if (q_due.size() > 0 && cycle >= q_due[0]) begin
                rsp_valid = 1'b1;
                rsp_data  = q_data[0];
                rsp_tag   = q_tag[0];
                rsp_issued++;
            end else begin
                rsp_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/mem_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_unit_defs.svh"

module mem_unit_tb
    import mem_unit_pkg::*;
;

    localparam int MAX_DELAY = 8;
    localparam int N_FETCH   = 40;
    localparam int N_WRRD    = 40;
    localparam int N_ARB     = 30;
    localparam int N_RAND    = 80;
    localparam int TOTAL     = N_FETCH + N_WRRD + 2 * N_ARB + 2 * N_RAND;
    localparam int LIMIT     = TOTAL * (MAX_DELAY + 4) + 1000;

    logic clk;
    logic reset;
    logic always_ready;

    logic                         icache_req_valid;
    logic [`MEM_ADDR_WIDTH-1:0]   icache_req_addr;
    logic [`ICACHE_TAG_WIDTH-1:0] icache_req_tag;
    logic                         icache_req_ready;
    logic                         icache_rsp_valid;
    logic [`MEM_DATA_WIDTH-1:0]   icache_rsp_data;
    logic [`ICACHE_TAG_WIDTH-1:0] icache_rsp_tag;
    logic                         icache_rsp_ready;
    logic                         dcache_req_valid;
    logic                         dcache_req_rw;
    logic [`MEM_BYTEEN_WIDTH-1:0] dcache_req_byteen;
    logic [`MEM_ADDR_WIDTH-1:0]   dcache_req_addr;
    logic [`MEM_DATA_WIDTH-1:0]   dcache_req_data;
    logic [`DCACHE_TAG_WIDTH-1:0] dcache_req_tag;
    logic                         dcache_req_ready;
    logic                         dcache_rsp_valid;
    logic [`MEM_DATA_WIDTH-1:0]   dcache_rsp_data;
    logic [`DCACHE_TAG_WIDTH-1:0] dcache_rsp_tag;
    logic                         dcache_rsp_ready;
    logic                         mem_req_valid;
    logic                         mem_req_rw;
    logic [`MEM_BYTEEN_WIDTH-1:0] mem_req_byteen;
    logic [`MEM_ADDR_WIDTH-1:0]   mem_req_addr;
    logic [`MEM_DATA_WIDTH-1:0]   mem_req_data;
    logic [`MEM_TAG_WIDTH-1:0]    mem_req_tag;
    logic                         mem_req_ready;
    logic                         mem_rsp_valid;
    logic [`MEM_DATA_WIDTH-1:0]   mem_rsp_data;
    logic [`MEM_TAG_WIDTH-1:0]    mem_rsp_tag;
    logic                         mem_rsp_ready;
    perf_ctr_t                    perf_mem_reads;
    perf_ctr_t                    perf_mem_writes;
    perf_ctr_t                    perf_mem_stalls;
    perf_ctr_t                    perf_mem_latency;

    // Scoreboard state
    icache_req_t ic_sent [$];
    dcache_req_t dc_sent [$];
    mem_rsp_t    ic_exp [$];
    mem_rsp_t    dc_exp [$];
    logic [`MEM_DATA_WIDTH-1:0] tb_mem [logic [`MEM_ADDR_WIDTH-1:0]];

    int errors, checks, tests, cycle;
    int ic_target, ic_issued, ic_accepts;
    int dc_target, dc_issued, dc_accepts;
    bit dense, rand_rsp, arb_phase;
    int last_fire, ic_mem_cnt, dc_mem_cnt;
    logic last_src;
    perf_ctr_t m_reads, m_writes, m_stalls, m_latency, m_pending;

    mem_unit mem_unit_inst (.*);

    mem_unit_mem_model #(.MAX_DELAY(MAX_DELAY)) mem_model (
        .clk          (clk),
        .reset        (reset),
        .always_ready (always_ready),
        .req_valid    (mem_req_valid),
        .req_rw       (mem_req_rw),
        .req_byteen   (mem_req_byteen),
        .req_addr     (mem_req_addr),
        .req_data     (mem_req_data),
        .req_tag      (mem_req_tag),
        .req_ready    (mem_req_ready),
        .rsp_valid    (mem_rsp_valid),
        .rsp_data     (mem_rsp_data),
        .rsp_tag      (mem_rsp_tag),
        .rsp_ready    (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fill rule for lines memory has not seen written
    function automatic logic [`MEM_DATA_WIDTH-1:0] expect_line(
        input logic [`MEM_ADDR_WIDTH-1:0] addr);
        if (tb_mem.exists(addr)) begin
            return tb_mem[addr];
        end
        return {6'h15, addr, 6'h2a, ~addr};
    endfunction

    function automatic logic [`MEM_DATA_WIDTH-1:0] merge_bytes(
        input logic [`MEM_DATA_WIDTH-1:0] old_line,
        input logic [`MEM_DATA_WIDTH-1:0] wdata,
        input logic [`MEM_BYTEEN_WIDTH-1:0] be);
        logic [`MEM_DATA_WIDTH-1:0] line;
        line = old_line;
        for (int i = 0; i < `MEM_BYTEEN_WIDTH; i++) begin
            if (be[i]) begin
                line[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return line;
    endfunction

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: mem_req got %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_icache_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: icache_rsp got %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_dcache_rsp(input mem_rsp_t got, input mem_rsp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: dcache_rsp got %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_perf(input string name, input perf_ctr_t got, input perf_ctr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: perf %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Turns one memory port transfer into expectations
    task automatic take_mem_req();
        mem_req_t    got;
        mem_req_t    exp;
        icache_req_t ir;
        dcache_req_t dr;
        logic        src;
        got = '{rw: mem_req_rw, byteen: mem_req_byteen, addr: mem_req_addr,
                data: mem_req_data, tag: mem_req_tag};
        src = mem_req_tag[`MEM_TAG_WIDTH-1];
        if (arb_phase && last_fire == cycle - 1 && src == last_src
                && ic_mem_cnt < N_ARB && dc_mem_cnt < N_ARB) begin
            errors++;
            $display("Error at %0t: source %0b granted twice in a row", $time, src);
        end
        last_fire = cycle;
        last_src  = src;
        if (!src) begin
            ic_mem_cnt++;
            if (ic_sent.size() == 0) begin
                errors++;
                $display("Memory request from the fetch client without a matching request");
                return;
            end
            ir  = ic_sent.pop_front();
            exp = '{rw: 1'b0, byteen: '0, addr: ir.addr, data: '0, tag: {2'b00, ir.tag}};
            check_mem_req(got, exp);
            ic_exp.push_back('{data: expect_line(ir.addr), tag: {2'b00, ir.tag}});
        end else begin
            dc_mem_cnt++;
            if (dc_sent.size() == 0) begin
                errors++;
                $display("Memory request from the data client without a matching request");
                return;
            end
            dr  = dc_sent.pop_front();
            exp = '{rw: dr.rw, byteen: dr.byteen, addr: dr.addr, data: dr.data,
                    tag: {1'b1, dr.tag}};
            check_mem_req(got, exp);
            if (dr.rw) begin
                tb_mem[dr.addr] = merge_bytes(expect_line(dr.addr), dr.data, dr.byteen);
            end else begin
                dc_exp.push_back('{data: expect_line(dr.addr), tag: {1'b0, dr.tag}});
            end
        end
    endtask

    // Monitor samples everything on the rising edge
    always @(posedge clk) begin
        mem_rsp_t got;
        cycle++;
        if (cycle > LIMIT) begin
            $display("Timeout: run did not drain within %0d cycles", LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end else if (!reset) begin
            if (icache_req_valid && icache_req_ready) begin
                ic_sent.push_back('{addr: icache_req_addr, tag: icache_req_tag});
                ic_accepts++;
            end
            if (dcache_req_valid && dcache_req_ready) begin
                dc_sent.push_back('{rw: dcache_req_rw, byteen: dcache_req_byteen,
                                    addr: dcache_req_addr, data: dcache_req_data,
                                    tag: dcache_req_tag});
                dc_accepts++;
            end
            m_latency += m_pending;
            if (mem_req_valid && !mem_req_ready) begin
                m_stalls++;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_rw) begin
                    m_writes++;
                end else begin
                    m_reads++;
                    m_pending++;
                end
                take_mem_req();
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                m_pending--;
            end
            if (icache_rsp_valid && icache_rsp_ready) begin
                got = '{data: icache_rsp_data, tag: {2'b00, icache_rsp_tag}};
                if (ic_exp.size() == 0) begin
                    errors++;
                    $display("Fetch response arrived with none outstanding");
                end else begin
                    check_icache_rsp(got, ic_exp.pop_front());
                end
            end
            if (dcache_rsp_valid && dcache_rsp_ready) begin
                got = '{data: dcache_rsp_data, tag: {1'b0, dcache_rsp_tag}};
                if (dc_exp.size() == 0) begin
                    errors++;
                    $display("Data response arrived with none outstanding");
                end else begin
                    check_dcache_rsp(got, dc_exp.pop_front());
                end
            end
        end
    end

    // Client drivers, a new request only after the last one was taken
    always @(negedge clk) begin
        if (!reset) begin
            if (ic_accepts == ic_issued) begin
                if (ic_issued < ic_target && (dense || $urandom % 2 == 0)) begin
                    icache_req_valid = 1'b1;
                    icache_req_addr  = `MEM_ADDR_WIDTH'($urandom);
                    icache_req_tag   = `ICACHE_TAG_WIDTH'($urandom);
                    ic_issued++;
                end else begin
                    icache_req_valid = 1'b0;
                end
            end
            if (dc_accepts == dc_issued) begin
                if (dc_issued < dc_target && (dense || $urandom % 2 == 0)) begin
                    dcache_req_valid  = 1'b1;
                    dcache_req_rw     = 1'($urandom);
                    dcache_req_byteen = `MEM_BYTEEN_WIDTH'($urandom);
                    // Small pool so reads hit earlier writes
                    dcache_req_addr   = 26'h100 + `MEM_ADDR_WIDTH'($urandom % 16);
                    dcache_req_data   = {$urandom, $urandom};
                    dcache_req_tag    = `DCACHE_TAG_WIDTH'($urandom);
                    dc_issued++;
                end else begin
                    dcache_req_valid = 1'b0;
                end
            end
            icache_rsp_ready = rand_rsp ? ($urandom % 4 != 0) : 1'b1;
            dcache_rsp_ready = rand_rsp ? ($urandom % 4 != 0) : 1'b1;
        end
    end

    task automatic run_phase(input string name, input int n_ic, input int n_dc,
                             input bit is_dense, input bit is_rand, input bit is_arb);
        int start_errors;
        start_errors = errors;
        @(posedge clk);
        dense        = is_dense;
        rand_rsp     = is_rand;
        arb_phase    = is_arb;
        always_ready = !is_rand;
        ic_mem_cnt   = 0;
        dc_mem_cnt   = 0;
        ic_target   += n_ic;
        dc_target   += n_dc;
        @(negedge clk);
        while (!(ic_accepts == ic_target && dc_accepts == dc_target && ic_sent.size() == 0
                 && dc_sent.size() == 0 && ic_exp.size() == 0 && dc_exp.size() == 0)) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        tests++;
        $display("Test %s done, %0d errors", name, errors - start_errors);
    endtask

    initial begin
        void'($urandom(63132));
        reset = 1'b1;
        always_ready = 1'b1;
        icache_req_valid = 1'b0;
        icache_req_addr = '0;
        icache_req_tag = '0;
        icache_rsp_ready = 1'b1;
        dcache_req_valid = 1'b0;
        dcache_req_rw = 1'b0;
        dcache_req_byteen = '0;
        dcache_req_addr = '0;
        dcache_req_data = '0;
        dcache_req_tag = '0;
        dcache_rsp_ready = 1'b1;
        errors = 0;
        checks = 0;
        tests = 0;
        cycle = 0;
        last_fire = -10;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_phase("fetch", N_FETCH, 0, 1'b0, 1'b0, 1'b0);
        run_phase("write_read", 0, N_WRRD, 1'b0, 1'b0, 1'b0);
        run_phase("arbitration", N_ARB, N_ARB, 1'b1, 1'b0, 1'b1);
        run_phase("random_backpressure", N_RAND, N_RAND, 1'b0, 1'b1, 1'b0);
        check_perf("reads", perf_mem_reads, m_reads);
        check_perf("writes", perf_mem_writes, m_writes);
        check_perf("stalls", perf_mem_stalls, m_stalls);
        check_perf("latency", perf_mem_latency, m_latency);
        tests++;
        $display("Test perf_counters done");
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_unit.f
+incdir+source
source/mem_unit_pkg.sv
source/mem_skid_buffer.sv
source/mem_req_arb.sv
source/mem_rsp_router.sv
source/mem_perf_counters.sv
source/mem_unit.sv
dv/mem_unit_mem_model.sv
dv/mem_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= mem_unit.f
TB_TOP    ?= mem_unit_tb
RTL_TOP   ?= mem_unit
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "NO ERRORS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
